// ==== flist.f ====
+incdir+.
isaPkg.sv
busPkg.sv
idRegFile.sv
instrDecoder.sv
aluExecute.sv
wbExecSlave.sv
aluCoreTop.sv
aluCore_sva.sv
tbAluCore.sv

// ==== tbAluCore.sv ====
`timescale 1ns/1ps

`include "core_macros.svh"

module tbAluCore;
    import isaPkg::*;

    // Upper bounds per bus access, used for the run limit
    localparam int wrCycles   = 5;
    localparam int rdCycles   = 4;
    localparam int dumpCycles = `REG_COUNT * rdCycles;
    localparam int testCycles = dumpCycles
                              + (9 * wrCycles + 12 * rdCycles)
                              + 6 * (14 * wrCycles + 10 * rdCycles)
                              + 3 * (2 * wrCycles + 13 * (wrCycles + rdCycles))
                              + (9 * wrCycles + 2 * rdCycles + dumpCycles)
                              + (200 * wrCycles + dumpCycles);
    localparam int timeoutLimit = 3 * (testCycles + 3);

    logic                 Clk;
    logic                 rstN;
    logic                 cycI;
    logic                 stbI;
    logic                 weI;
    logic [`WB_ADR_W-1:0] adrI;
    logic [`XLEN-1:0]     datI;
    logic [3:0]           selI;
    logic [`XLEN-1:0]     datO;
    logic                 ackO;
    logic                 errO;

    // Reference copy of the architectural registers
    logic [`XLEN-1:0] model [0:`REG_COUNT-1];
    int cycleCount = 0;

    aluCoreTop dut_i (
        .Clk  (Clk),
        .rstN (rstN),
        .cycI (cycI),
        .stbI (stbI),
        .weI  (weI),
        .adrI (adrI),
        .datI (datI),
        .selI (selI),
        .datO (datO),
        .ackO (ackO),
        .errO (errO)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    always @(posedge Clk) begin
        cycleCount++;
        if (cycleCount > timeoutLimit) begin
            $display("Timeout: tests did not finish within %0d cycles", timeoutLimit);
            $display("*** FAILED ***");
            $fatal(1, "simulation timed out");
        end
    end

    //////////////////////////////
    // Checking and bus access
    //////////////////////////////

    task automatic checkEq(input logic [`XLEN-1:0] actual, input logic [`XLEN-1:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic awaitResponse(output logic ack, output logic err,
                                 output logic [`XLEN-1:0] data);
        int waited;
        waited = 1;
        @(negedge Clk);
        while (!(ackO || errO)) begin
            if (waited >= 8) begin
                $display("Bus did not respond to the request at address %h within 8 cycles", adrI);
                $display("*** FAILED ***");
                $fatal(1, "no bus response");
            end else begin
                @(negedge Clk);
                waited++;
            end
        end
        ack  = ackO;
        err  = errO;
        data = datO;
        // Request stays up across the edge where the slave retires it
        @(negedge Clk);
        cycI = 1'b0;
        stbI = 1'b0;
        weI  = 1'b0;
    endtask

    task automatic wbWrite(input logic [`WB_ADR_W-1:0] adr, input logic [`XLEN-1:0] dat,
                           input logic [3:0] sel, output logic ack, output logic err);
        logic [`XLEN-1:0] busData;
        @(negedge Clk);
        cycI = 1'b1;
        stbI = 1'b1;
        weI  = 1'b1;
        adrI = adr;
        datI = dat;
        selI = sel;
        awaitResponse(ack, err, busData);
    endtask

    task automatic wbRead(input logic [`WB_ADR_W-1:0] adr, output logic [`XLEN-1:0] data,
                          output logic ack, output logic err);
        @(negedge Clk);
        cycI = 1'b1;
        stbI = 1'b1;
        weI  = 1'b0;
        adrI = adr;
        selI = 4'hF;
        awaitResponse(ack, err, data);
    endtask

    //////////////////////////////
    // Instruction encoding and model
    //////////////////////////////

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm12, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
        return {imm12, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] upper, input logic [4:0] rd);
        return {upper, rd, LUI};
    endfunction

    // Applies one word to the model, returns whether it is legal
    function automatic logic modelExec(input logic [31:0] w);
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        alt;
        logic        legal;
        rd    = w[11:7];
        f3    = w[14:12];
        f7    = w[31:25];
        a     = model[w[19:15]];
        b     = '0;
        res   = '0;
        alt   = (f7 == 7'h20);
        legal = 1'b1;
        if (w[6:0] == LUI) begin
            res = {w[31:12], 12'h000};
        end else if (w[6:0] == OP || w[6:0] == OP_IMM) begin
            if (w[6:0] == OP) begin
                b     = model[w[24:20]];
                legal = (f7 == 7'h00) || (alt && (f3 == 3'd0 || f3 == 3'd5));
            end else begin
                b = {{20{w[31]}}, w[31:20]};
                if (f3 == 3'd1) begin
                    legal = (f7 == 7'h00);
                end else if (f3 == 3'd5) begin
                    legal = (f7 == 7'h00) || alt;
                end
                // Bit 30 of an I-type immediate only matters for right shifts
                alt = alt && (f3 == 3'd5);
            end
            case (f3)
                3'd0: res = alt ? a - b : a + b;
                3'd1: res = a << b[4:0];
                3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: res = (a < b) ? 32'd1 : 32'd0;
                3'd4: res = a ^ b;
                3'd5: begin
                    if (alt) begin
                        res = $signed(a) >>> b[4:0];
                    end else begin
                        res = a >> b[4:0];
                    end
                end
                3'd6: res = a | b;
                default: res = a & b;
            endcase
        end else begin
            legal = 1'b0;
        end
        if (legal && rd != 5'd0) begin
            model[rd] = res;
        end
        return legal;
    endfunction

    task automatic runInstr(input logic [31:0] w, input string what);
        logic legal;
        logic ack;
        logic err;
        legal = modelExec(w);
        wbWrite(`ADDR_INSTR, w, 4'hF, ack, err);
        checkEq(ack, legal, $sformatf("%s ackO", what));
        checkEq(err, !legal, $sformatf("%s errO", what));
    endtask

    task automatic checkReg(input int n);
        logic [`XLEN-1:0] data;
        logic             ack;
        logic             err;
        wbRead(8'(`ADDR_REG_BASE + 4 * n), data, ack, err);
        checkEq(ack, 1'b1, $sformatf("x%0d read ackO", n));
        checkEq(data, model[n], $sformatf("x%0d value", n));
    endtask

    task automatic dumpCheck();
        for (int n = 0; n < `REG_COUNT; n++) begin
            checkReg(n);
        end
    endtask

    // LUI plus ADDI, upper part rounded for the sign of the low 12 bits
    task automatic loadConst(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] upper;
        upper = v + 32'h800;
        runInstr(encU(upper[31:12], rd), "LUI load");
        runInstr(encI(v[11:0], rd, f3AddSub, rd), "ADDI load");
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////

    task automatic testResetState();
        logic [`XLEN-1:0] data;
        logic             ack;
        logic             err;
        for (int n = 0; n < `REG_COUNT; n++) begin
            wbRead(8'(`ADDR_REG_BASE + 4 * n), data, ack, err);
            checkEq(ack, 1'b1, $sformatf("reset read x%0d ackO", n));
            checkEq(data, 32'h0, $sformatf("reset value x%0d", n));
        end
    endtask

    task automatic testLoads();
        runInstr(encU(20'h12345, 5), "LUI x5");
        runInstr(encI(12'hFFF, 0, f3AddSub, 6), "ADDI x6 -1");
        runInstr(encI(12'h800, 0, f3AddSub, 7), "ADDI x7 -2048");
        runInstr(encI(12'h7FF, 5, f3AddSub, 8), "ADDI x8 +2047");
        runInstr(encI(12'hFFB, 6, f3AddSub, 9), "ADDI x9 -5");
        runInstr(encU(20'hFFFFF, 10), "LUI x10");
        runInstr(encI(12'h007, 6, f3AddSub, 0), "ADDI x0");
        loadConst(11, 32'hDEAD_BEEF);
        for (int n = 0; n < 12; n++) begin
            checkReg(n);
        end
    endtask

    task automatic testRegReg();
        logic [31:0] srcA [0:5];
        logic [31:0] srcB [0:5];
        logic [2:0]  f3;
        logic [6:0]  f7;
        srcA = '{32'h7FFF_FFFF, 32'h8000_0000, 32'hFFFF_FFFF,
                 32'h1234_5678, 32'h8000_0000, 32'h0000_0000};
        srcB = '{32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0001,
                 32'h0000_001F, 32'h0000_0021, 32'h8000_0000};
        for (int p = 0; p < 6; p++) begin
            loadConst(1, srcA[p]);
            loadConst(2, srcB[p]);
            // Eight base ops, then SUB and SRA
            for (int k = 0; k < 10; k++) begin
                f3 = (k < 8) ? 3'(k) : ((k == 8) ? f3AddSub : f3SrlSra);
                f7 = (k < 8) ? f7Base : f7Alt;
                runInstr(encR(f7, 2, 1, f3, 5'(3 + k)),
                         $sformatf("OP f3=%0d f7=%h pair %0d", f3, f7, p));
                checkReg(3 + k);
            end
        end
    endtask

    task automatic testRegImm();
        logic [31:0] src [0:2];
        logic [2:0]  f3s [0:12];
        logic [11:0] imms [0:12];
        src  = '{32'h8000_0001, 32'h7FFF_FFF0, 32'hFFFF_FFFF};
        f3s  = '{3'd0, 3'd0, 3'd2, 3'd2, 3'd3, 3'd4, 3'd6,
                 3'd7, 3'd1, 3'd5, 3'd5, 3'd5, 3'd5};
        // SRLI 4 and SRAI 4 side by side, then SRAI 31 and SRLI 0
        imms = '{12'h7FF, 12'h800, 12'hFFF, 12'h001, 12'hFFF, 12'hFFF, 12'h555,
                 12'hF0F, 12'h01F, 12'h004, 12'h404, 12'h41F, 12'h000};
        for (int s = 0; s < 3; s++) begin
            loadConst(11, src[s]);
            for (int k = 0; k < 13; k++) begin
                runInstr(encI(imms[k], 11, f3s[k], 5'(13 + k)),
                         $sformatf("OP_IMM f3=%0d imm=%h source %0d", f3s[k], imms[k], s));
                checkReg(13 + k);
            end
        end
    endtask

    task automatic expectErr(input logic ack, input logic err, input string what);
        checkEq(ack, 1'b0, $sformatf("%s ackO", what));
        checkEq(err, 1'b1, $sformatf("%s errO", what));
    endtask

    task automatic testErrors();
        logic [`XLEN-1:0] data;
        logic             ack;
        logic             err;
        runInstr(32'h0000_00EF, "JAL opcode");
        runInstr(32'h0000_8183, "load opcode");
        runInstr(encR(7'h01, 2, 1, f3AddSub, 3), "MUL funct7");
        runInstr(encR(f7Alt, 2, 1, f3Xor, 4), "XOR with alternate funct7");
        runInstr(encI({f7Alt, 5'd3}, 1, f3Sll, 5), "SLLI with alternate funct7");
        runInstr(encI({7'h10, 5'd3}, 1, f3SrlSra, 6), "right shift with bad funct7");
        wbWrite(8'h04, encI(12'h001, 0, f3AddSub, 7), 4'hF, ack, err);
        expectErr(ack, err, "write to unmapped address");
        wbWrite(`ADDR_INSTR, encI(12'h001, 0, f3AddSub, 7), 4'h3, ack, err);
        expectErr(ack, err, "partial instruction write");
        wbWrite(8'h84, 32'h0000_0001, 4'hF, ack, err);
        expectErr(ack, err, "write into register window");
        wbRead(8'h40, data, ack, err);
        expectErr(ack, err, "read below register window");
        wbRead(8'h82, data, ack, err);
        expectErr(ack, err, "misaligned register read");
        dumpCheck();
    endtask

    task automatic testRandom();
        logic [31:0] w;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [6:0]  f7;
        for (int i = 0; i < 200; i++) begin
            rd  = 5'($urandom);
            rs1 = 5'($urandom);
            rs2 = 5'($urandom);
            f3  = 3'($urandom);
            case ($urandom % 3)
                0: begin
                    // Alternate funct7 only on ADD/SUB and SRL/SRA
                    f7 = ((f3 == f3AddSub || f3 == f3SrlSra) && ($urandom % 2)) ? f7Alt : f7Base;
                    w  = encR(f7, rs2, rs1, f3, rd);
                end
                1: begin
                    if (f3 == f3Sll || f3 == f3SrlSra) begin
                        f7 = (f3 == f3SrlSra && ($urandom % 2)) ? f7Alt : f7Base;
                        w  = encI({f7, rs2}, rs1, f3, rd);
                    end else begin
                        w = encI(12'($urandom), rs1, f3, rd);
                    end
                end
                default: w = encU(20'($urandom), rd);
            endcase
            runInstr(w, $sformatf("random instruction %0d (%h)", i, w));
        end
        dumpCheck();
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        void'($urandom(32'hbbc6_a80a));
        rstN = 1'b0;
        cycI = 1'b0;
        stbI = 1'b0;
        weI  = 1'b0;
        adrI = '0;
        datI = '0;
        selI = 4'h0;
        for (int n = 0; n < `REG_COUNT; n++) begin
            model[n] = '0;
        end
        repeat (3) @(posedge Clk);
        @(negedge Clk);
        rstN = 1'b1;

        testResetState();
        testLoads();
        testRegReg();
        testRegImm();
        testErrors();
        testRandom();

        // Bus handshake assertions count their own failures
        if (dut_i.slave_i.sva_i.assertFails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("Bus handshake assertions failed %0d times",
                     dut_i.slave_i.sva_i.assertFails);
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== aluCore_sva.sv ====
`timescale 1ns/1ps

module aluCoreSva (
    input logic Clk,
    input logic rstN,
    input logic cycI,
    input logic stbI,
    input logic ackO,
    input logic errO
);

    // Number of failed assertions so far
    int assertFails = 0;

    //////////////////////////////
    // Wishbone response rules
    //////////////////////////////

    // One response kind per request
    respExclusive: assert property (@(posedge Clk) disable iff (!rstN) !(ackO && errO))
        else begin
            assertFails++;
            $error("ackO and errO high together");
        end

    ackOneCycle: assert property (@(posedge Clk) disable iff (!rstN) ackO |=> !ackO)
        else begin
            assertFails++;
            $error("ackO held longer than one cycle");
        end

    errOneCycle: assert property (@(posedge Clk) disable iff (!rstN) errO |=> !errO)
        else begin
            assertFails++;
            $error("errO held longer than one cycle");
        end

    // Responses only while the host still requests
    ackInRequest: assert property (@(posedge Clk) disable iff (!rstN) ackO |-> (cycI && stbI))
        else begin
            assertFails++;
            $error("ackO outside an active request");
        end

    errInRequest: assert property (@(posedge Clk) disable iff (!rstN) errO |-> (cycI && stbI))
        else begin
            assertFails++;
            $error("errO outside an active request");
        end

endmodule

bind wbExecSlave aluCoreSva sva_i (
    .Clk  (Clk),
    .rstN (rstN),
    .cycI (cycI),
    .stbI (stbI),
    .ackO (ackO),
    .errO (errO)
);

// ==== aluCoreTop.sv ====
`timescale 1ns/1ps

`include "core_macros.svh"

module aluCoreTop (
    input  logic                 Clk,
    input  logic                 rstN,
    input  logic                 cycI,
    input  logic                 stbI,
    input  logic                 weI,
    input  logic [`WB_ADR_W-1:0] adrI,
    input  logic [`XLEN-1:0]     datI,
    input  logic [3:0]           selI,
    output logic [`XLEN-1:0]     datO,
    output logic                 ackO,
    output logic                 errO
);
    import isaPkg::*;

    logic [`XLEN-1:0]       instr;
    logic                   execStrobe;
    logic [`REG_ADDR_W-1:0] hostAddr;
    logic [`XLEN-1:0]       hostData;
    logic [`REG_ADDR_W-1:0] rs1Addr;
    logic [`REG_ADDR_W-1:0] rs2Addr;
    logic [`REG_ADDR_W-1:0] rdAddr;
    logic [`XLEN-1:0]       imm;
    logic                   useImm;
    logic                   writeEn;
    logic                   illegal;
    aluOpT                  aluOp;
    logic [`XLEN-1:0]       rs1Data;
    logic [`XLEN-1:0]       rs2Data;
    logic                   rdWrEn;
    logic [`REG_ADDR_W-1:0] wrAddr;
    logic [`XLEN-1:0]       rdWrData;

    //////////////////////////////
    // Bus front end
    //////////////////////////////

    wbExecSlave slave_i (
        .Clk        (Clk),
        .rstN       (rstN),
        .cycI       (cycI),
        .stbI       (stbI),
        .weI        (weI),
        .adrI       (adrI),
        .datI       (datI),
        .selI       (selI),
        .illegal    (illegal),
        .hostData   (hostData),
        .instr      (instr),
        .execStrobe (execStrobe),
        .hostAddr   (hostAddr),
        .datO       (datO),
        .ackO       (ackO),
        .errO       (errO)
    );

    //////////////////////////////
    // Decode and operand read
    //////////////////////////////

    // Decoder and register file both see the held instruction at once
    instrDecoder decoder_i (
        .instr   (instr),
        .rs1Addr (rs1Addr),
        .rs2Addr (rs2Addr),
        .rdAddr  (rdAddr),
        .imm     (imm),
        .useImm  (useImm),
        .writeEn (writeEn),
        .illegal (illegal),
        .aluOp   (aluOp)
    );

    idRegFile regFile_i (
        .Clk      (Clk),
        .rstN     (rstN),
        .rs1Addr  (rs1Addr),
        .rs2Addr  (rs2Addr),
        .hostAddr (hostAddr),
        .wrAddr   (wrAddr),
        .rdWrData (rdWrData),
        .rdWrEn   (rdWrEn),
        .rs1Data  (rs1Data),
        .rs2Data  (rs2Data),
        .hostData (hostData)
    );

    //////////////////////////////
    // Execute and write-back
    //////////////////////////////

    aluExecute execute_i (
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .imm        (imm),
        .useImm     (useImm),
        .writeEn    (writeEn),
        .execStrobe (execStrobe),
        .aluOp      (aluOp),
        .rdAddr     (rdAddr),
        .rdWrEn     (rdWrEn),
        .wrAddr     (wrAddr),
        .rdWrData   (rdWrData)
    );

endmodule

// ==== wbExecSlave.sv ====
`timescale 1ns/1ps

`include "core_macros.svh"

module wbExecSlave (
    input  logic                   Clk,
    input  logic                   rstN,
    input  logic                   cycI,
    input  logic                   stbI,
    input  logic                   weI,
    input  logic [`WB_ADR_W-1:0]   adrI,
    input  logic [`XLEN-1:0]       datI,
    input  logic [3:0]             selI,
    input  logic                   illegal,
    input  logic [`XLEN-1:0]       hostData,
    output logic [`XLEN-1:0]       instr,
    output logic                   execStrobe,
    output logic [`REG_ADDR_W-1:0] hostAddr,
    output logic [`XLEN-1:0]       datO,
    output logic                   ackO,
    output logic                   errO
);
    import busPkg::*;

    wbStateT              state;
    accessT               access;
    logic                 reqValid;
    logic                 inWindow;
    logic [`WB_ADR_W-1:0] winOffset;

    //////////////////////////////
    // Address decode
    //////////////////////////////

    assign reqValid  = cycI && stbI;
    assign winOffset = adrI - `ADDR_REG_BASE;
    // Word aligned and inside the register window
    assign inWindow  = (adrI >= `ADDR_REG_BASE)
                    && (winOffset[`WB_ADR_W-1:`REG_ADDR_W+2] == '0)
                    && (winOffset[1:0] == 2'b00);
    assign hostAddr  = winOffset[`REG_ADDR_W+1:2];

    always_comb begin
        access = NONE;
        if (reqValid) begin
            // Instruction words must be written whole
            if (weI && adrI == `ADDR_INSTR && selI == 4'hF) begin
                access = INSTR;
            end else if (!weI && inWindow) begin
                access = REGRD;
            end
        end
    end

    //////////////////////////////
    // Control FSM
    //////////////////////////////

    assign execStrobe = (state == EXEC);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
            ackO  <= 1'b0;
            errO  <= 1'b0;
        end else begin
            // Responses are single-cycle pulses
            ackO <= 1'b0;
            errO <= 1'b0;
            case (state)
                IDLE: begin
                    if (access == INSTR) begin
                        state <= EXEC;
                    end else if (access == REGRD) begin
                        ackO  <= 1'b1;
                        state <= RESP;
                    end else if (reqValid) begin
                        // Unmapped, wrong direction or partial instruction write
                        errO  <= 1'b1;
                        state <= RESP;
                    end
                end
                EXEC: begin
                    // Register write lands on this same edge
                    ackO  <= !illegal;
                    errO  <= illegal;
                    state <= RESP;
                end
                RESP:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge Clk) begin
        if (state == IDLE && access == INSTR) begin
            instr <= datI;
        end
        if (state == IDLE && access == REGRD) begin
            datO <= hostData;
        end
    end

endmodule

// ==== aluExecute.sv ====
`timescale 1ns/1ps

`include "core_macros.svh"

module aluExecute (
    input  logic [`XLEN-1:0]       rs1Data,
    input  logic [`XLEN-1:0]       rs2Data,
    input  logic [`XLEN-1:0]       imm,
    input  logic                   useImm,
    input  logic                   writeEn,
    input  logic                   execStrobe,
    input  isaPkg::aluOpT          aluOp,
    input  logic [`REG_ADDR_W-1:0] rdAddr,
    output logic                   rdWrEn,
    output logic [`REG_ADDR_W-1:0] wrAddr,
    output logic [`XLEN-1:0]       rdWrData
);
    import isaPkg::*;

    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] result;

    //////////////////////////////
    // Operand select
    //////////////////////////////

    assign opA   = rs1Data;
    assign opB   = useImm ? imm : rs2Data;
    // RV32I shifts only look at the low five bits
    assign shamt = opB[4:0];

    //////////////////////////////
    // ALU
    //////////////////////////////

    always_comb begin
        case (aluOp)
            ALU_ADD:  result = opA + opB;
            ALU_SUB:  result = opA - opB;
            ALU_SLL:  result = opA << shamt;
            ALU_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, opA < opB};
            ALU_XOR:  result = opA ^ opB;
            ALU_SRL:  result = opA >> shamt;
            ALU_SRA:  result = $signed(opA) >>> shamt;
            ALU_OR:   result = opA | opB;
            ALU_AND:  result = opA & opB;
            ALU_PASSB: begin
                // LUI path, immediate already shifted up by the decoder
                result = opB;
            end
            default:  result = '0;
        endcase
    end

    //////////////////////////////
    // Write-back
    //////////////////////////////

    // Strobe marks the single EXEC cycle
    assign rdWrEn   = writeEn && execStrobe;
    assign wrAddr   = rdAddr;
    assign rdWrData = result;

endmodule

// ==== instrDecoder.sv ====
`timescale 1ns/1ps

`include "core_macros.svh"

module instrDecoder (
    input  logic [`XLEN-1:0]       instr,
    output logic [`REG_ADDR_W-1:0] rs1Addr,
    output logic [`REG_ADDR_W-1:0] rs2Addr,
    output logic [`REG_ADDR_W-1:0] rdAddr,
    output logic [`XLEN-1:0]       imm,
    output logic                   useImm,
    output logic                   writeEn,
    output logic                   illegal,
    output isaPkg::aluOpT          aluOp
);
    import isaPkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;

    //////////////////////////////
    // Field extraction
    //////////////////////////////

    assign rdAddr  = instr[11:7];
    assign funct3  = instr[14:12];
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];
    assign funct7  = instr[31:25];

    // Enable follows legality, so illegal words never write back
    assign writeEn = !illegal;

    //////////////////////////////
    // Opcode and function decode
    //////////////////////////////

    always_comb begin
        illegal = 1'b0;
        useImm  = 1'b0;
        aluOp   = ALU_ADD;
        // I-type immediate, sign extended
        imm     = {{(`XLEN-12){instr[31]}}, instr[31:20]};

        case (opcodeT'(instr[6:0]))
            OP: begin
                case (funct3)
                    f3AddSub: aluOp = (funct7 == f7Alt) ? ALU_SUB : ALU_ADD;
                    f3Sll:    aluOp = ALU_SLL;
                    f3Slt:    aluOp = ALU_SLT;
                    f3Sltu:   aluOp = ALU_SLTU;
                    f3Xor:    aluOp = ALU_XOR;
                    f3SrlSra: aluOp = (funct7 == f7Alt) ? ALU_SRA : ALU_SRL;
                    f3Or:     aluOp = ALU_OR;
                    default:  aluOp = ALU_AND;
                endcase
                // Alternate funct7 only exists for SUB and SRA
                if (funct7 == f7Alt) begin
                    illegal = (funct3 != f3AddSub) && (funct3 != f3SrlSra);
                end else if (funct7 != f7Base) begin
                    illegal = 1'b1;
                end
            end
            OP_IMM: begin
                useImm = 1'b1;
                case (funct3)
                    f3AddSub: aluOp = ALU_ADD;
                    f3Slt:    aluOp = ALU_SLT;
                    f3Sltu:   aluOp = ALU_SLTU;
                    f3Xor:    aluOp = ALU_XOR;
                    f3Or:     aluOp = ALU_OR;
                    f3And:    aluOp = ALU_AND;
                    f3Sll: begin
                        aluOp   = ALU_SLL;
                        illegal = (funct7 != f7Base);
                    end
                    default: begin
                        // Bit 30 picks arithmetic shift, shamt stays in imm[4:0]
                        aluOp   = instr[30] ? ALU_SRA : ALU_SRL;
                        illegal = (funct7 != f7Base) && (funct7 != f7Alt);
                    end
                endcase
            end
            LUI: begin
                useImm = 1'b1;
                aluOp  = ALU_PASSB;
                imm    = {instr[31:12], 12'b0};
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

// ==== idRegFile.sv ====
`timescale 1ns/1ps

`include "core_macros.svh"

module idRegFile (
    input  logic                   Clk,
    input  logic                   rstN,
    input  logic [`REG_ADDR_W-1:0] rs1Addr,
    input  logic [`REG_ADDR_W-1:0] rs2Addr,
    input  logic [`REG_ADDR_W-1:0] hostAddr,
    input  logic [`REG_ADDR_W-1:0] wrAddr,
    input  logic [`XLEN-1:0]       rdWrData,
    input  logic                   rdWrEn,
    output logic [`XLEN-1:0]       rs1Data,
    output logic [`XLEN-1:0]       rs2Data,
    output logic [`XLEN-1:0]       hostData
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`REG_COUNT-1];

    function automatic logic [`XLEN-1:0] readReg(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        return regs[addr];
    endfunction

    // Three independent combinational read ports
    assign rs1Data  = readReg(rs1Addr);
    assign rs2Data  = readReg(rs2Addr);
    assign hostData = readReg(hostAddr);

    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rdWrEn && wrAddr != '0) begin
            // Writes to x0 dropped here
            regs[wrAddr] <= rdWrData;
        end
    end

endmodule

// ==== busPkg.sv ====
package busPkg;

    //////////////////////////////
    // Wishbone slave sequencing
    //////////////////////////////

    // EXEC only used for instruction writes
    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        RESP
    } wbStateT;

    // Kind of request seen in IDLE
    // NONE also covers unmapped or malformed accesses
    typedef enum logic [1:0] {
        NONE,
        INSTR,
        REGRD
    } accessT;

endpackage

// ==== isaPkg.sv ====
package isaPkg;

    //////////////////////////////
    // Major opcodes
    //////////////////////////////

    // Only the three groups this core executes
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111
    } opcodeT;

    //////////////////////////////
    // ALU operations
    //////////////////////////////

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASSB
    } aluOpT;

    // funct3 field values, shared by OP and OP_IMM
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    // funct7 values accepted on OP and on immediate shifts
    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt  = 7'b0100000;

endpackage

// ==== core_macros.svh ====
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

//////////////////////////////
// Datapath widths fixed by RV32I
//////////////////////////////

`define XLEN        32
`define REG_ADDR_W  5
`define REG_COUNT   32

//////////////////////////////
// Wishbone byte address map
//////////////////////////////

`define WB_ADR_W       8
// Instruction port, write only
`define ADDR_INSTR     8'h00
// Register n at base + 4*n, read only
`define ADDR_REG_BASE  8'h80

`endif
